//--- cef_defines.svh
/*
  geometry of the coefficient reconstruction buffer
  luma fills words 0..127 of each bank, chroma 128..191
  the address width must hold the full depth
*/
`ifndef CEF_DEFINES_SVH
`define CEF_DEFINES_SVH

// coefficient and bank word
`define CEF_COEFF_W     16
`define CEF_LANE_N      8

// bank array
`define CEF_BANK_N      4
`define CEF_BANK_DEPTH  192
`define CEF_ADDR_W      8

`endif

//--- cef_pkg.sv
/*
  types shared by the buffer RTL
  plane code 1 is unused; it decodes as chroma
*/
`include "cef_defines.svh"

package cef_pkg;

  typedef enum logic [1:0] {
    Y = 2'd0,
    U = 2'd2,
    V = 2'd3
  } plane_e;

  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } blk_size_e;

  typedef logic [`CEF_COEFF_W-1:0] coeff_t;
  typedef coeff_t [`CEF_LANE_N-1:0] lane_t;
  typedef lane_t [`CEF_BANK_N-1:0] row_t;

  typedef struct packed {
    plane_e     plane;
    blk_size_e  size;
    logic [3:0] x;
    logic [3:0] y;
    logic [4:0] idx;
  } blk_pos_t;

  // ----------------------------------------
  // bank address, two decodings of one word
  // ----------------------------------------
  typedef struct packed {
    logic       zero;
    logic       y3;
    logic       x3;
    logic [2:0] mid;
    logic [1:0] lo;
  } luma_addr_t;

  typedef struct packed {
    logic       one;
    logic       zero;
    logic       pl;
    logic [2:0] mid;
    logic [1:0] lo;
  } chroma_addr_t;

  typedef union packed {
    luma_addr_t   luma;
    chroma_addr_t chroma;
  } bank_addr_u;

  // bank index per lane
  typedef struct packed {
    logic [1:0] lane3;
    logic [1:0] lane2;
    logic [1:0] lane1;
    logic [1:0] lane0;
  } lane_map_t;

  typedef struct packed {
    lane_map_t lane_map;
    logic      half;
    logic      half_lo;
  } route_t;

  typedef struct packed {
    logic                   wr_ena;
    logic [`CEF_LANE_N-1:0] coeff_ena;
    bank_addr_u             addr;
    lane_t                  dat;
  } bank_wr_t;

endpackage

//--- cef_bank_addr.sv
/*
  block position to bank addresses and lane route, purely combinational
  chroma ignores bit 3 of both grid coordinates
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module cef_bank_addr (
  input  cef_pkg::blk_pos_t                     pos_i,
  output cef_pkg::bank_addr_u [`CEF_BANK_N-1:0] addr_o,
  output cef_pkg::route_t                       route_o
);
  import cef_pkg::*;

  logic [2:0]                  mid;
  logic [1:0]                  rot;
  logic [`CEF_BANK_N-1:0][1:0] lo;

  // middle field, shared by all banks
  always_comb begin
    unique case (pos_i.size)
      SIZE_04: mid = pos_i.y[2:0];
      SIZE_08: mid = {pos_i.y[2:1], pos_i.idx[2]};
      SIZE_16: mid = {pos_i.y[2], pos_i.idx[3:2]};
      SIZE_32: mid = pos_i.idx[4:2];
    endcase
  end

  // small blocks rotate the low field by the 8x8 column
  always_comb begin
    unique case (pos_i.x[2:1])
      2'd0: rot = 2'd0;
      2'd1: rot = 2'd2;
      2'd2: rot = 2'd3;
      2'd3: rot = 2'd1;
    endcase
  end

  always_comb begin
    for (int b = 0; b < `CEF_BANK_N; b++) begin
      unique case (pos_i.size)
        SIZE_04, SIZE_08: lo[b] = 2'(b) + rot;
        SIZE_16:          lo[b] = {pos_i.idx[1], pos_i.x[2] ^ 1'(b & 1)};
        SIZE_32:          lo[b] = pos_i.idx[1:0];
      endcase
    end
  end

  always_comb begin
    for (int b = 0; b < `CEF_BANK_N; b++) begin
      if (pos_i.plane == Y) begin
        addr_o[b].luma.zero = 1'b0;
        addr_o[b].luma.y3   = pos_i.y[3];
        addr_o[b].luma.x3   = pos_i.x[3];
        addr_o[b].luma.mid  = mid;
        addr_o[b].luma.lo   = lo[b];
      end else begin
        addr_o[b].chroma.one  = 1'b1;
        addr_o[b].chroma.zero = 1'b0;
        addr_o[b].chroma.pl   = pos_i.plane[0];
        addr_o[b].chroma.mid  = mid;
        addr_o[b].chroma.lo   = lo[b];
      end
    end
  end

  // ----------------------------------------
  // lane map, banks for lanes 3..0
  // ----------------------------------------
  always_comb begin
    unique case (pos_i.size)
      SIZE_04, SIZE_08: begin
        unique case (pos_i.x[2:1])
          2'd0: route_o.lane_map = {2'd0, 2'd1, 2'd2, 2'd3};
          2'd1: route_o.lane_map = {2'd2, 2'd3, 2'd0, 2'd1};
          2'd2: route_o.lane_map = {2'd1, 2'd2, 2'd3, 2'd0};
          2'd3: route_o.lane_map = {2'd3, 2'd0, 2'd1, 2'd2};
        endcase
      end
      SIZE_16: begin
        unique case ({pos_i.x[2], pos_i.idx[1]})
          2'd0: route_o.lane_map = {2'd0, 2'd2, 2'd1, 2'd3};
          2'd1: route_o.lane_map = {2'd2, 2'd0, 2'd3, 2'd1};
          2'd2: route_o.lane_map = {2'd1, 2'd3, 2'd2, 2'd0};
          2'd3: route_o.lane_map = {2'd3, 2'd1, 2'd0, 2'd2};
        endcase
      end
      SIZE_32: begin
        unique case (pos_i.idx[1:0])
          2'd0: route_o.lane_map = {2'd0, 2'd2, 2'd1, 2'd3};
          2'd1: route_o.lane_map = {2'd1, 2'd3, 2'd2, 2'd0};
          2'd2: route_o.lane_map = {2'd2, 2'd0, 2'd3, 2'd1};
          2'd3: route_o.lane_map = {2'd3, 2'd1, 2'd0, 2'd2};
        endcase
      end
    endcase
    route_o.half    = (pos_i.size == SIZE_04);
    route_o.half_lo = pos_i.x[0];
  end

endmodule

//--- cef_wr_router.sv
/*
  steers a write row onto the four banks
  4x4 rows carry data in the high half of each lane only;
  the odd grid column lands in the low half of the bank word
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module cef_wr_router (
  input  logic                                  wr_ena_i,
  input  cef_pkg::bank_addr_u [`CEF_BANK_N-1:0] addr_i,
  input  cef_pkg::route_t                       route_i,
  input  cef_pkg::row_t                         wr_dat_i,
  output cef_pkg::bank_wr_t   [`CEF_BANK_N-1:0] bank_wr_o
);
  import cef_pkg::*;

  localparam int HALF = `CEF_LANE_N / 2;

  logic [`CEF_BANK_N-1:0][1:0] lane_bank;
  logic [`CEF_LANE_N-1:0]      coeff_ena;
  row_t                        lane_dat;

  assign lane_bank = route_i.lane_map;

  // coefficient enables
  always_comb begin
    if (!wr_ena_i) begin
      coeff_ena = '0;
    end else if (!route_i.half) begin
      coeff_ena = '1;
    end else if (route_i.half_lo) begin
      coeff_ena = {{HALF{1'b0}}, {HALF{1'b1}}};
    end else begin
      coeff_ena = {{HALF{1'b1}}, {HALF{1'b0}}};
    end
  end

  // duplicate high halves for 4x4
  always_comb begin
    for (int l = 0; l < `CEF_BANK_N; l++) begin
      if (route_i.half) begin
        lane_dat[l] = {wr_dat_i[l][`CEF_LANE_N-1 -: HALF],
                       wr_dat_i[l][`CEF_LANE_N-1 -: HALF]};
      end else begin
        lane_dat[l] = wr_dat_i[l];
      end
    end
  end

  // ----------------------------------------
  // per bank, pick the lane mapped onto it
  // ----------------------------------------
  always_comb begin
    for (int b = 0; b < `CEF_BANK_N; b++) begin
      bank_wr_o[b].wr_ena    = wr_ena_i;
      bank_wr_o[b].coeff_ena = coeff_ena;
      bank_wr_o[b].addr      = addr_i[b];
      bank_wr_o[b].dat       = '0;
      for (int l = 0; l < `CEF_BANK_N; l++) begin
        if (lane_bank[l] == 2'(b)) begin
          bank_wr_o[b].dat = lane_dat[l];
        end
      end
    end
  end

endmodule

//--- cef_bank.sv
/*
  one single-port coefficient bank, one access per cycle
  a read wins the port; a write in the same cycle is dropped
  read data appears one cycle after the request and holds
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module cef_bank (
  input  logic                clk,
  input  logic                rstn,
  input  cef_pkg::bank_wr_t   bank_wr_i,
  input  logic                rd_ena_i,
  input  cef_pkg::bank_addr_u rd_addr_i,
  output cef_pkg::lane_t      rd_dat_o
);
  import cef_pkg::*;

  lane_t                  mem [`CEF_BANK_DEPTH];
  logic [`CEF_ADDR_W-1:0] mem_addr;
  logic                   wr_act;

  assign mem_addr = rd_ena_i ? rd_addr_i : bank_wr_i.addr;
  assign wr_act   = bank_wr_i.wr_ena & ~rd_ena_i;

  always_ff @(posedge clk) begin
    if (wr_act) begin
      for (int c = 0; c < `CEF_LANE_N; c++) begin
        if (bank_wr_i.coeff_ena[c]) begin
          mem[mem_addr][c] <= bank_wr_i.dat[c];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_dat_o <= '0;
    end else if (rd_ena_i) begin
      rd_dat_o <= mem[mem_addr];
    end
  end

  // port is shared, caller must not overlap the two
  a_no_collision: assert property (@(posedge clk) disable iff (!rstn)
    !(bank_wr_i.wr_ena && rd_ena_i))
    else $error("write and read in the same cycle");

  a_wr_depth: assert property (@(posedge clk) disable iff (!rstn)
    bank_wr_i.wr_ena |-> (bank_wr_i.addr < `CEF_BANK_DEPTH))
    else $error("write address beyond bank depth");

endmodule

//--- cef_rd_merger.sv
/*
  reorders the bank outputs into a row
  the lane map is captured with the read request so it lines up
  with the registered bank data one cycle later
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module cef_rd_merger (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              rd_ena_i,
  input  cef_pkg::route_t                   route_i,
  input  cef_pkg::lane_t [`CEF_BANK_N-1:0]  lane_i,
  output cef_pkg::row_t                     rd_dat_o
);
  import cef_pkg::*;

  lane_map_t                   map_q;
  logic [`CEF_BANK_N-1:0][1:0] lane_bank;
  logic [`CEF_BANK_N-1:0]      bank_seen;

  // identity map out of reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      map_q <= {2'd3, 2'd2, 2'd1, 2'd0};
    end else if (rd_ena_i) begin
      map_q <= route_i.lane_map;
    end
  end

  assign lane_bank = map_q;

  always_comb begin
    for (int l = 0; l < `CEF_BANK_N; l++) begin
      rd_dat_o[l] = lane_i[lane_bank[l]];
    end
  end

  // ----------------------------------------
  // every bank feeds exactly one lane
  // ----------------------------------------
  always_comb begin
    bank_seen = '0;
    for (int l = 0; l < `CEF_BANK_N; l++) begin
      bank_seen[lane_bank[l]] = 1'b1;
    end
  end

  a_map_perm: assert property (@(posedge clk) disable iff (!rstn)
    bank_seen == '1)
    else $error("registered lane map is not a permutation");

endmodule

//--- rec_buf_cef.sv
/*
  coefficient reconstruction buffer, one write or one read per cycle
  read data follows the request by one cycle and holds until the next read
  no handshake; write and read in the same cycle is illegal
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module rec_buf_cef (
  input  logic              clk,
  input  logic              rstn,
  // write port
  input  logic              wr_ena_i,
  input  cef_pkg::blk_pos_t wr_pos_i,
  input  cef_pkg::row_t     wr_dat_i,
  // read port
  input  logic              rd_ena_i,
  input  cef_pkg::blk_pos_t rd_pos_i,
  output cef_pkg::row_t     rd_dat_o
);
  import cef_pkg::*;

  bank_addr_u [`CEF_BANK_N-1:0] wr_addr;
  bank_addr_u [`CEF_BANK_N-1:0] rd_addr;
  route_t                       wr_route;
  route_t                       rd_route;
  bank_wr_t   [`CEF_BANK_N-1:0] bank_wr;
  lane_t      [`CEF_BANK_N-1:0] bank_rd_dat;

  // ----------------------------------------
  // address and route
  // ----------------------------------------
  cef_bank_addr u_wr_addr (
    .pos_i   (wr_pos_i),
    .addr_o  (wr_addr),
    .route_o (wr_route)
  );

  cef_bank_addr u_rd_addr (
    .pos_i   (rd_pos_i),
    .addr_o  (rd_addr),
    .route_o (rd_route)
  );

  cef_wr_router u_wr_router (
    .wr_ena_i  (wr_ena_i),
    .addr_i    (wr_addr),
    .route_i   (wr_route),
    .wr_dat_i  (wr_dat_i),
    .bank_wr_o (bank_wr)
  );

  // ----------------------------------------
  // banks
  // ----------------------------------------
  for (genvar b = 0; b < `CEF_BANK_N; b++) begin : g_bank
    cef_bank u_bank (
      .clk       (clk),
      .rstn      (rstn),
      .bank_wr_i (bank_wr[b]),
      .rd_ena_i  (rd_ena_i),
      .rd_addr_i (rd_addr[b]),
      .rd_dat_o  (bank_rd_dat[b])
    );
  end

  cef_rd_merger u_rd_merger (
    .clk      (clk),
    .rstn     (rstn),
    .rd_ena_i (rd_ena_i),
    .route_i  (rd_route),
    .lane_i   (bank_rd_dat),
    .rd_dat_o (rd_dat_o)
  );

endmodule

//--- tb_clk_gen.sv
/*
  clock and reset for the testbench
  10 ns period, reset low for 3 cycles and released on a falling edge
*/
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

//--- tb_rec_buf_cef.sv
/*
  table driven testbench for the coefficient reconstruction buffer
  inputs change on falling edges, rd_dat_o is checked on every falling edge
  against the last expected read row; writes and reads never share a cycle
*/
`timescale 1ns/10ps
`include "cef_defines.svh"

module tb_rec_buf_cef;
  import cef_pkg::*;

  typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_e;

  typedef struct {
    op_e      op;
    blk_pos_t pos;
    int       seed;
    int       test;
  } entry_t;

  localparam int TEST_N      = 7;
  localparam int RST_TIMEOUT = 20;

  logic        clk;
  logic        rstn;
  logic        wr_ena;
  blk_pos_t    wr_pos;
  row_t        wr_dat;
  logic        rd_ena;
  blk_pos_t    rd_pos;
  row_t        rd_dat;

  entry_t      tab [$];
  row_t        rows [$];
  row_t        shadow [logic [16:0]];
  logic [15:0] lfsr_q;
  row_t        exp_row;
  string       exp_what;
  string       test_name [TEST_N];
  int          test_chk [TEST_N];
  int          test_err [TEST_N];
  int          cur;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  rec_buf_cef i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .wr_ena_i (wr_ena),
    .wr_pos_i (wr_pos),
    .wr_dat_i (wr_dat),
    .rd_ena_i (rd_ena),
    .rd_pos_i (rd_pos),
    .rd_dat_o (rd_dat)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per data bit
  task automatic make_row(output row_t r);
    logic [$bits(row_t)-1:0] flat;
    flat = '0;
    for (int b = 0; b < $bits(row_t); b++) begin
      flat   = {flat[$bits(row_t)-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    r = flat;
  endtask

  function automatic blk_pos_t make_pos(plane_e pl, blk_size_e sz, int x, int y, int idx);
    blk_pos_t p;
    p.plane = pl;
    p.size  = sz;
    p.x     = 4'(x);
    p.y     = 4'(y);
    p.idx   = 5'(idx);
    return p;
  endfunction

  // one key per stored row: a 32 wide row holds 32/width block rows,
  // a block spans width/4 grid units, chroma has no grid bit 3
  function automatic logic [16:0] block_key(input blk_pos_t pos);
    blk_pos_t p;
    p = pos;
    if (p.plane != Y) begin
      p.x[3] = 1'b0;
      p.y[3] = 1'b0;
    end
    case (p.size)
      SIZE_04: begin
        p.x[0] = 1'b0;
        p.idx  = '0;
      end
      SIZE_08: begin
        p.x[0]     = 1'b0;
        p.y[0]     = 1'b0;
        p.idx[1:0] = '0;
      end
      SIZE_16: begin
        p.x[1:0] = '0;
        p.y[1:0] = '0;
        p.idx[0] = 1'b0;
      end
      default: begin
        p.x[2:0] = '0;
        p.y[2:0] = '0;
      end
    endcase
    return p;
  endfunction

  task automatic add_entry(input op_e op, input int test, input blk_pos_t pos);
    entry_t e;
    row_t   r;
    e.op   = op;
    e.test = test;
    e.pos  = pos;
    e.seed = -1;
    if (op == OP_WRITE) begin
      make_row(r);
      rows.push_back(r);
      e.seed = rows.size() - 1;
    end
    tab.push_back(e);
  endtask

  // a 4x4 pair shares a row: even block in the high half of each lane
  task automatic update_shadow(input blk_pos_t pos, input row_t dat);
    logic [16:0] k;
    row_t        r;
    k = block_key(pos);
    if (pos.size != SIZE_04) begin
      shadow[k] = dat;
    end else begin
      r = shadow.exists(k) ? shadow[k] : '0;
      for (int l = 0; l < `CEF_BANK_N; l++) begin
        if (pos.x[0]) begin
          r[l][3:0] = dat[l][7:4];
        end else begin
          r[l][7:4] = dat[l][7:4];
        end
      end
      shadow[k] = r;
    end
  endtask

  task automatic check_row(input row_t got, input row_t exp, input string what);
    logic [1:0] lane;
    lane = '0;
    test_chk[cur]++;
    if (got !== exp) begin
      test_err[cur]++;
      for (int l = 0; l < `CEF_BANK_N; l++) begin
        if (got[l] !== exp[l]) begin
          lane = 2'(l);
        end
      end
      $display("MISMATCH at %0d ns: %s, lane %0d got %h expected %h",
               $time, what, lane, got[lane], exp[lane]);
    end
  endtask

  task automatic apply_entry(input entry_t e);
    wr_ena = 1'b0;
    rd_ena = 1'b0;
    case (e.op)
      OP_WRITE: begin
        wr_ena = 1'b1;
        wr_pos = e.pos;
        wr_dat = rows[e.seed];
        update_shadow(e.pos, rows[e.seed]);
      end
      OP_READ: begin
        rd_ena   = 1'b1;
        rd_pos   = e.pos;
        exp_row  = shadow[block_key(e.pos)];
        exp_what = $sformatf("read plane %0d size %0d x %0d y %0d row %0d",
                             e.pos.plane, e.pos.size, e.pos.x, e.pos.y, e.pos.idx);
      end
      default: begin
      end
    endcase
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  task automatic build_table();
    plane_e planes [3];
    planes = '{Y, U, V};
    add_entry(OP_IDLE, 0, make_pos(Y, SIZE_04, 0, 0, 0));
    add_entry(OP_IDLE, 0, make_pos(Y, SIZE_04, 0, 0, 0));
    for (int i = 0; i < 32; i++) add_entry(OP_WRITE, 1, make_pos(Y, SIZE_32, 0, 0, i));
    for (int i = 0; i < 32; i++) add_entry(OP_READ, 1, make_pos(Y, SIZE_32, 0, 0, i));
    // two 16x16 in the x bit 3 quarter
    for (int x = 8; x <= 12; x += 4) begin
      for (int i = 0; i < 16; i += 2) add_entry(OP_WRITE, 2, make_pos(Y, SIZE_16, x, 0, i));
    end
    for (int x = 8; x <= 12; x += 4) begin
      for (int i = 0; i < 16; i += 2) add_entry(OP_READ, 2, make_pos(Y, SIZE_16, x, 0, i));
    end
    // one 8x8 per rotation, in the y bit 3 quarter
    for (int x = 0; x < 8; x += 2) begin
      for (int i = 0; i < 8; i += 4) add_entry(OP_WRITE, 3, make_pos(Y, SIZE_08, x, 8, i));
    end
    for (int x = 0; x < 8; x += 2) begin
      for (int i = 0; i < 8; i += 4) add_entry(OP_READ, 3, make_pos(Y, SIZE_08, x, 8, i));
    end
    for (int x = 0; x < 8; x++) add_entry(OP_WRITE, 4, make_pos(Y, SIZE_04, x, 12, 0));
    for (int x = 0; x < 8; x += 2) add_entry(OP_READ, 4, make_pos(Y, SIZE_04, x, 12, 0));
    foreach (planes[p]) add_entry(OP_WRITE, 5, make_pos(planes[p], SIZE_08, 2, 8, 4));
    foreach (planes[p]) add_entry(OP_READ, 5, make_pos(planes[p], SIZE_08, 2, 8, 4));
    add_entry(OP_READ, 5, make_pos(Y, SIZE_32, 0, 0, 0));
    // reads of every kind in consecutive cycles
    add_entry(OP_READ, 6, make_pos(Y, SIZE_32, 0, 0, 7));
    add_entry(OP_READ, 6, make_pos(Y, SIZE_16, 12, 0, 6));
    add_entry(OP_READ, 6, make_pos(Y, SIZE_08, 6, 8, 4));
    add_entry(OP_READ, 6, make_pos(Y, SIZE_04, 4, 12, 0));
    add_entry(OP_READ, 6, make_pos(U, SIZE_08, 2, 8, 4));
    add_entry(OP_READ, 6, make_pos(V, SIZE_08, 2, 8, 4));
    add_entry(OP_IDLE, 6, make_pos(Y, SIZE_04, 0, 0, 0));
    add_entry(OP_IDLE, 6, make_pos(Y, SIZE_04, 0, 0, 0));
  endtask

  task automatic wait_reset(output bit ok);
    int n;
    n = 0;
    while (rstn !== 1'b1 && n < RST_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    ok = (rstn === 1'b1);
  endtask

  task automatic report_test(input int t);
    $display("test %0d %-14s %0d checks, %0d errors", t, test_name[t], test_chk[t], test_err[t]);
  endtask

  // a check on a falling edge belongs to the entry driven one edge earlier
  task automatic run_table();
    cur = tab[0].test;
    foreach (tab[i]) begin
      @(negedge clk);
      check_row(rd_dat, exp_row, exp_what);
      if (tab[i].test != cur) begin
        report_test(cur);
        cur = tab[i].test;
      end
      apply_entry(tab[i]);
    end
    @(negedge clk);
    check_row(rd_dat, exp_row, exp_what);
    report_test(cur);
  endtask

  task automatic finish_run(input bit timed_out);
    int chk;
    int err;
    chk = 0;
    err = 0;
    foreach (test_chk[t]) begin
      chk += test_chk[t];
      err += test_err[t];
    end
    $display("%0d tests, %0d checks, %0d errors", TEST_N, chk, err);
    if (timed_out || err != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    wr_ena    = 1'b0;
    wr_pos    = '0;
    wr_dat    = '0;
    rd_ena    = 1'b0;
    rd_pos    = '0;
    lfsr_q    = 16'd15452;
    exp_row   = '0;
    exp_what  = "output after reset";
    test_name = '{"reset value", "32x32 luma", "16x16 luma", "8x8 luma",
                  "4x4 pairs", "plane select", "back to back"};
    foreach (test_chk[t]) begin
      test_chk[t] = 0;
      test_err[t] = 0;
    end
    build_table();
    wait_reset(ok);
    if (!ok) begin
      $display("reset still asserted after %0d cycles", RST_TIMEOUT);
      finish_run(1'b1);
    end else begin
      run_table();
      finish_run(1'b0);
    end
  end

endmodule

//--- rec_buf_cef.f
+incdir+.
cef_pkg.sv
cef_bank_addr.sv
cef_wr_router.sv
cef_bank.sv
cef_rd_merger.sv
rec_buf_cef.sv
tb_clk_gen.sv
tb_rec_buf_cef.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_rec_buf_cef
FLIST = rec_buf_cef.f
LOG   = sim.log

BIN  = obj_dir/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
